// File: logic/noc_chain_pkg.sv
/* shared widths, FIR taps, cipher round keys, spare block constants
   and the processor state type for the NoC chain */
`default_nettype none

package noc_chain_pkg;

    // datapath widths
    localparam int noc_dw   = 32;
    localparam int arith_dw = 32;

    // generator decimation factor
    localparam int acc_const = 4;

    // symmetric four-tap FIR, x[n] first
    localparam logic [noc_dw-1:0] fir_coef [4] = '{32'd1, 32'd3, 32'd3, 32'd1};

    // one key per cipher round
    localparam logic [noc_dw-1:0] round_key [4] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476
    };

    // rotate-left amount inside a round
    localparam int rot_amt = 5;

    // OR masks for the eight adder tree inputs
    localparam logic [arith_dw-1:0] spare_mask [8] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476,
        32'hc3d2e1f0, 32'h5a827999, 32'h6ed9eba1, 32'h8f1bbcdc
    };

    // golden ratio constant for the spare multiplier
    localparam logic [arith_dw-1:0] spare_mult = 32'h9e3779b9;

    // words per router input FIFO
    localparam int fifo_depth = 4;

    // done doubles as the cycle where the ciphertext is presented
    typedef enum logic [1:0] {idle, round, done} proc_state_t;

endpackage

`default_nettype wire

// File: logic/traffic_generator.sv
/* four-tap FIR over the input stream, decimated by four,
   with a one-cycle valid pulse per output word */
`timescale 1ns/1ps
`default_nettype none

module traffic_generator (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [noc_chain_pkg::noc_dw-1:0] data_in,
    output logic [noc_chain_pkg::noc_dw-1:0] tg_data,
    output logic                             tg_valid
);
    import noc_chain_pkg::*;

    logic [$clog2(acc_const)-1:0] phase;
    // x[n-1], x[n-2], x[n-3]; data_in itself is x[n]
    logic [noc_dw-1:0]            history [3];
    logic [noc_dw-1:0]            tap_sum;
    logic                         last_phase;

    // weighted tap sum, wraps mod 2^32
    assign tap_sum = fir_coef[0] * data_in
                   + fir_coef[1] * history[0]
                   + fir_coef[2] * history[1]
                   + fir_coef[3] * history[2];

    assign last_phase = (int'(phase) == acc_const - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase      <= '0;
            tg_valid   <= 1'b0;
            history[0] <= '0;
            history[1] <= '0;
            history[2] <= '0;
        end else begin
            phase      <= last_phase ? '0 : phase + 1'b1;
            // valid lands in the cycle after phase 3
            tg_valid   <= last_phase;
            // shift every cycle, not only on output
            history[0] <= data_in;
            history[1] <= history[0];
            history[2] <= history[1];
        end
    end

    // output word only moves on the decimation edge
    always_ff @(posedge clk) begin
        if (last_phase) begin
            tg_data <= tap_sum;
        end
    end

endmodule

`default_nettype wire

// File: logic/master_interface.sv
/* two-entry buffer turning generator pulses into a valid/ready stream,
   with a sticky overflow flag */
`timescale 1ns/1ps
`default_nettype none

module master_interface (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [noc_chain_pkg::noc_dw-1:0] tg_data,
    input  logic                             tg_valid,
    output logic [noc_chain_pkg::noc_dw-1:0] m_data,
    output logic                             m_valid,
    input  logic                             m_ready,
    output logic                             overflow
);
    import noc_chain_pkg::*;

    logic [noc_dw-1:0] buffer [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic              full;
    logic              push;
    logic              pop;

    assign full    = (count == 2'd2);
    // pulse while full is dropped and flagged
    assign push    = tg_valid && !full;
    assign pop     = m_valid && m_ready;
    // oldest word heads the stream
    assign m_valid = (count != 2'd0);
    assign m_data  = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
            // sticky until reset
            if (tg_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= tg_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/noc_router.sv
/* single router hop: four-deep input FIFO feeding a registered
   valid/ready output stage */
`timescale 1ns/1ps
`default_nettype none

module noc_router (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [noc_chain_pkg::noc_dw-1:0] in_data,
    input  logic                             in_valid,
    output logic                             in_ready,
    output logic [noc_chain_pkg::noc_dw-1:0] out_data,
    output logic                             out_valid,
    input  logic                             out_ready
);
    import noc_chain_pkg::*;

    logic [noc_dw-1:0]                mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]    wr_ptr;
    logic [$clog2(fifo_depth)-1:0]    rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0]  count;
    logic                             fifo_push;
    logic                             fifo_pop;

    // back-pressure straight from occupancy
    assign in_ready  = (int'(count) != fifo_depth);
    assign fifo_push = in_valid && in_ready;
    // refill output stage when empty or draining
    assign fifo_pop  = (count != '0) && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (fifo_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + ($bits(count))'(fifo_push) - ($bits(count))'(fifo_pop);
            // hold while the next hop stalls
            if (fifo_pop) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // storage and output word
    always_ff @(posedge clk) begin
        if (fifo_push) begin
            mem[wr_ptr] <= in_data;
        end
        if (fifo_pop) begin
            out_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// File: logic/slave_interface.sv
/* one-entry receive register at the network edge,
   emptied when the processor takes the word */
`timescale 1ns/1ps
`default_nettype none

module slave_interface (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [noc_chain_pkg::noc_dw-1:0] na_data,
    input  logic                             na_valid,
    output logic                             na_ready,
    output logic [noc_chain_pkg::noc_dw-1:0] s_data,
    output logic                             s_valid,
    input  logic                             s_take
);
    logic full;
    logic accept;

    // only an empty register accepts
    assign na_ready = !full;
    assign accept   = na_valid && na_ready;
    assign s_valid  = full;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (s_take) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end
    end

    // word held until taken
    always_ff @(posedge clk) begin
        if (accept) begin
            s_data <= na_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/traffic_processor.sv
/* four-round cipher FSM and ciphertext register,
   one word every four cycles */
`timescale 1ns/1ps
`default_nettype none

module traffic_processor (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [noc_chain_pkg::noc_dw-1:0] s_data,
    input  logic                             s_valid,
    output logic                             s_take,
    output logic [noc_chain_pkg::noc_dw-1:0] enc_data,
    output logic                             enc_valid
);
    import noc_chain_pkg::*;

    proc_state_t       state;
    logic [1:0]        rnd;
    logic [noc_dw-1:0] cipher;

    // xor key, rotate left, add key
    function automatic logic [noc_dw-1:0] cipher_round(
        input logic [noc_dw-1:0] x,
        input logic [1:0]        r
    );
        logic [noc_dw-1:0] t;
        t = x ^ round_key[r];
        return ((t << rot_amt) | (t >> (noc_dw - rot_amt))) + round_key[r];
    endfunction

    // take cycle also runs round 0
    assign s_take    = (state != round) && s_valid;
    assign enc_valid = (state == done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            rnd      <= 2'd0;
            enc_data <= '0;
        end else begin
            case (state)
                round: begin
                    rnd <= rnd + 1'b1;
                    // final round goes straight to the output register
                    if (rnd == 2'd3) begin
                        enc_data <= cipher_round(cipher, rnd);
                        state    <= done;
                    end
                end
                default: begin
                    // done behaves like idle so back-to-back words keep pace
                    if (s_take) begin
                        rnd   <= 2'd1;
                        state <= round;
                    end else begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // working cipher state
    always_ff @(posedge clk) begin
        if (s_take) begin
            cipher <= cipher_round(s_data, 2'd0);
        end else if (state == round) begin
            cipher <= cipher_round(cipher, rnd);
        end
    end

endmodule

`default_nettype wire

// File: logic/spare_arith.sv
/* free-running counter, eight masked inputs, three-stage adder tree
   and constant multiplier */
`timescale 1ns/1ps
`default_nettype none

module spare_arith (
    input  logic                                clk,
    input  logic                                reset,
    output logic [noc_chain_pkg::arith_dw-1:0]  mult_res
);
    import noc_chain_pkg::*;

    logic [arith_dw-1:0] counter;
    logic [arith_dw-1:0] spare_in [8];
    logic [arith_dw-1:0] stage_one [4];
    logic [arith_dw-1:0] stage_two [2];
    logic [arith_dw-1:0] sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // input i is (i*c + i) | mask, input 0 is c | mask
    for (genvar i = 0; i < 8; i++) begin : gen_inputs
        localparam logic [arith_dw-1:0] mul_k = (i == 0) ? 1 : i;
        localparam logic [arith_dw-1:0] add_k = i;

        always_ff @(posedge clk) begin
            if (reset) begin
                spare_in[i] <= '0;
            end else begin
                spare_in[i] <= (mul_k * counter + add_k) | spare_mask[i];
            end
        end
    end

    // 8-4-2-1 reduction, one register per level
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_one <= '{default: '0};
            stage_two <= '{default: '0};
            sum       <= '0;
        end else begin
            for (int k = 0; k < 4; k++) begin
                stage_one[k] <= spare_in[2*k] + spare_in[2*k+1];
            end
            stage_two[0] <= stage_one[0] + stage_one[1];
            stage_two[1] <= stage_one[2] + stage_one[3];
            sum          <= stage_two[0] + stage_two[1];
        end
    end

    // low word of the product only
    assign mult_res = sum * spare_mult;

endmodule

`default_nettype wire

// File: logic/spread_noc_chain.sv
/* top level: generator, two-hop NoC chain, processor, spare arithmetic
   and the masked output */
`timescale 1ns/1ps
`default_nettype none

module spread_noc_chain (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [noc_chain_pkg::noc_dw-1:0] data_in,
    output logic [noc_chain_pkg::noc_dw-1:0] data_out,
    output logic                             data_valid
);
    import noc_chain_pkg::*;

    // generator to master interface
    logic [noc_dw-1:0]   tg_data;
    logic                tg_valid;
    // master interface to router_one
    logic [noc_dw-1:0]   m_data;
    logic                m_valid;
    logic                m_ready;
    logic                overflow;
    // router_one to router_two
    logic [noc_dw-1:0]   r1_data;
    logic                r1_valid;
    logic                r1_ready;
    // router_two to slave interface
    logic [noc_dw-1:0]   na_data;
    logic                na_valid;
    logic                na_ready;
    // slave interface to processor
    logic [noc_dw-1:0]   s_data;
    logic                s_valid;
    logic                s_take;
    logic [noc_dw-1:0]   enc_data;
    logic                enc_valid;
    // spare block, not on the network
    logic [arith_dw-1:0] mult_res;

    traffic_generator tg (
        .clk(clk), .reset(reset), .data_in(data_in),
        .tg_data(tg_data), .tg_valid(tg_valid)
    );

    master_interface mi (
        .clk(clk), .reset(reset), .tg_data(tg_data), .tg_valid(tg_valid),
        .m_data(m_data), .m_valid(m_valid), .m_ready(m_ready), .overflow(overflow)
    );

    noc_router router_one (
        .clk(clk), .reset(reset),
        .in_data(m_data), .in_valid(m_valid), .in_ready(m_ready),
        .out_data(r1_data), .out_valid(r1_valid), .out_ready(r1_ready)
    );

    noc_router router_two (
        .clk(clk), .reset(reset),
        .in_data(r1_data), .in_valid(r1_valid), .in_ready(r1_ready),
        .out_data(na_data), .out_valid(na_valid), .out_ready(na_ready)
    );

    slave_interface si (
        .clk(clk), .reset(reset),
        .na_data(na_data), .na_valid(na_valid), .na_ready(na_ready),
        .s_data(s_data), .s_valid(s_valid), .s_take(s_take)
    );

    traffic_processor tp (
        .clk(clk), .reset(reset), .s_data(s_data), .s_valid(s_valid),
        .s_take(s_take), .enc_data(enc_data), .enc_valid(enc_valid)
    );

    spare_arith sa (
        .clk(clk), .reset(reset), .mult_res(mult_res)
    );

    // network result masked by the spare product
    assign data_out   = enc_data & mult_res;
    assign data_valid = enc_valid;

endmodule

`default_nettype wire

// File: verification/spread_noc_chain_checker.sv
/* bound checker: reference model of the FIR, cipher and spare block,
   with concurrent assertions on the chain outputs */
`timescale 1ns/1ps
`default_nettype none

module spread_noc_chain_checker (
    input logic                               clk,
    input logic                               reset,
    input logic [noc_chain_pkg::noc_dw-1:0]   data_in,
    input logic [noc_chain_pkg::noc_dw-1:0]   data_out,
    input logic                               data_valid,
    input logic [noc_chain_pkg::noc_dw-1:0]   enc_data,
    input logic                               overflow,
    input logic [noc_chain_pkg::arith_dw-1:0] mult_res
);
    import noc_chain_pkg::*;

    int                  fail_count = 0;
    // FIR model, m_hist[0] is x[n-1]
    logic [1:0]          m_phase;
    logic [noc_dw-1:0]   m_hist [3];
    // expected plaintexts, oldest at q_rd
    logic [noc_dw-1:0]   m_plain [32];
    logic [4:0]          q_wr;
    logic [4:0]          q_rd;
    logic [5:0]          q_count;
    logic                q_push;
    // last ciphertext seen and the one due now
    logic [noc_dw-1:0]   m_enc;
    logic [noc_dw-1:0]   exp_enc;
    // spare counter and three-cycle sum history
    logic [arith_dw-1:0] m_counter;
    logic [arith_dw-1:0] m_in_sum;
    logic [arith_dw-1:0] m_sum_hist [3];
    logic [arith_dw-1:0] exp_mult;
    // pulse spacing
    logic [2:0]          since_valid;
    logic                seen_valid;

    // taps 1 3 3 1, x[n] first
    function automatic logic [noc_dw-1:0] fir_output(
        input logic [noc_dw-1:0] x0, x1, x2, x3
    );
        logic [noc_dw-1:0] taps [4];
        logic [noc_dw-1:0] acc;
        taps[0] = x0;
        taps[1] = x1;
        taps[2] = x2;
        taps[3] = x3;
        acc = '0;
        for (int k = 0; k < 4; k++) begin
            acc = acc + fir_coef[k] * taps[k];
        end
        return acc;
    endfunction

    // four rounds of rotl5(s ^ key) + key
    function automatic logic [noc_dw-1:0] encrypt(input logic [noc_dw-1:0] plain);
        logic [noc_dw-1:0] s;
        logic [noc_dw-1:0] t;
        s = plain;
        for (int r = 0; r < 4; r++) begin
            t = s ^ round_key[r];
            s = {t[noc_dw-6:0], t[noc_dw-1:noc_dw-5]} + round_key[r];
        end
        return s;
    endfunction

    // sum of the eight masked inputs for counter value c
    function automatic logic [arith_dw-1:0] masked_sum(input logic [arith_dw-1:0] c);
        logic [arith_dw-1:0] acc;
        logic [arith_dw-1:0] term;
        acc = '0;
        for (int i = 0; i < 8; i++) begin
            if (i == 0) begin
                term = c;
            end else begin
                term = c * arith_dw'(i) + arith_dw'(i);
            end
            acc = acc + (term | spare_mask[i]);
        end
        return acc;
    endfunction

    assign q_push = (m_phase == 2'd3);

    always_comb begin
        // enc_data changes in the pulse cycle itself
        exp_enc  = data_valid ? encrypt(m_plain[q_rd]) : m_enc;
        exp_mult = m_sum_hist[2] * spare_mult;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_phase     <= 2'd0;
            m_hist      <= '{default: '0};
            q_wr        <= 5'd0;
            q_rd        <= 5'd0;
            q_count     <= 6'd0;
            m_enc       <= '0;
            m_counter   <= '0;
            m_in_sum    <= '0;
            m_sum_hist  <= '{default: '0};
            since_valid <= 3'd0;
            seen_valid  <= 1'b0;
        end else begin
            m_phase   <= m_phase + 2'd1;
            m_hist[0] <= data_in;
            m_hist[1] <= m_hist[0];
            m_hist[2] <= m_hist[1];
            if (q_push) begin
                m_plain[q_wr] <= fir_output(data_in, m_hist[0], m_hist[1], m_hist[2]);
                q_wr          <= q_wr + 5'd1;
            end
            if (data_valid) begin
                m_enc <= exp_enc;
                q_rd  <= q_rd + 5'd1;
            end
            q_count <= q_count + 6'(q_push) - 6'(data_valid);
            // registered inputs, then three tree levels
            m_counter     <= m_counter + 1'b1;
            m_in_sum      <= masked_sum(m_counter);
            m_sum_hist[0] <= m_in_sum;
            m_sum_hist[1] <= m_sum_hist[0];
            m_sum_hist[2] <= m_sum_hist[1];
            if (data_valid) begin
                since_valid <= 3'd0;
            end else if (since_valid != 3'd7) begin
                since_valid <= since_valid + 3'd1;
            end
            seen_valid <= seen_valid | data_valid;
        end
    end

    a_data_out: assert property (@(posedge clk) disable iff (reset)
        data_out == (exp_enc & exp_mult))
    else begin
        $error("[ERROR] data_out got 0x%h expected 0x%h",
               $sampled(data_out), $sampled(exp_enc & exp_mult));
        fail_count++;
    end

    a_enc_data: assert property (@(posedge clk) disable iff (reset) enc_data == exp_enc)
    else begin
        $error("[ERROR] enc_data got 0x%h expected 0x%h", $sampled(enc_data), $sampled(exp_enc));
        fail_count++;
    end

    a_mult_res: assert property (@(posedge clk) disable iff (reset) mult_res == exp_mult)
    else begin
        $error("[ERROR] mult_res got 0x%h expected 0x%h", $sampled(mult_res), $sampled(exp_mult));
        fail_count++;
    end

    // quiet until the first ciphertext
    a_quiet_start: assert property (@(posedge clk) disable iff (reset)
        !seen_valid && !data_valid |-> data_out == '0)
    else begin
        $error("[ERROR] data_out got 0x%h expected 0x%h before first word",
               $sampled(data_out), 32'h0);
        fail_count++;
    end

    a_no_extra: assert property (@(posedge clk) disable iff (reset)
        data_valid |-> q_count != 6'd0)
    else begin
        $error("[ERROR] data_valid got 0x1 with expected word count 0x%h", $sampled(q_count));
        fail_count++;
    end

    // one pulse every fourth cycle once running
    a_spacing: assert property (@(posedge clk) disable iff (reset)
        seen_valid |-> (data_valid == (since_valid == 3'd3)))
    else begin
        $error("[ERROR] data_valid got 0x%h with 0x%h idle cycles since last pulse",
               $sampled(data_valid), $sampled(since_valid));
        fail_count++;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !overflow)
    else begin
        $error("[ERROR] overflow got 0x%h expected 0x0", $sampled(overflow));
        fail_count++;
    end

endmodule

bind spread_noc_chain spread_noc_chain_checker checker_inst (
    .clk(clk),
    .reset(reset),
    .data_in(data_in),
    .data_out(data_out),
    .data_valid(data_valid),
    .enc_data(enc_data),
    .overflow(overflow),
    .mult_res(mult_res)
);

`default_nettype wire

// File: verification/spread_noc_chain_tb.sv
/* testbench for the NoC chain: clock, reset, zero, constant and
   random input sections, a reset mid-run and run control */
`timescale 1ns/1ps
`default_nettype none

module spread_noc_chain_tb;
    import noc_chain_pkg::*;

    // covers startup latency plus slack
    localparam int wait_limit  = 64;
    localparam int mode_zero   = 0;
    localparam int mode_const  = 1;
    localparam int mode_random = 2;

    logic              clk = 1'b0;
    logic              reset;
    logic [noc_dw-1:0] data_in;
    logic [noc_dw-1:0] data_out;
    logic              data_valid;

    spread_noc_chain UUT (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .data_out(data_out),
        .data_valid(data_valid)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // checker count settles well before the falling edge
    always @(negedge clk) begin
        if (UUT.checker_inst.fail_count != 0) begin
            stop_with_failure("a checker assertion failed");
        end
    end

    task automatic drive_sample(input int mode);
        case (mode)
            mode_zero:  data_in = '0;
            mode_const: data_in = 32'h5a5ac3c3;
            default:    data_in = $urandom;
        endcase
    endtask

    // five rising edges with reset high
    task automatic hold_reset(input int mode);
        reset = 1'b1;
        repeat (5) begin
            @(negedge clk);
            drive_sample(mode);
        end
        reset = 1'b0;
    endtask

    // count data_valid pulses with a bounded wait for each
    task automatic collect_words(input int count, input int mode);
        int waited;
        for (int k = 0; k < count; k++) begin
            waited = 0;
            do begin
                @(negedge clk);
                drive_sample(mode);
                waited++;
            end while (!data_valid && waited < wait_limit);
            if (!data_valid) begin
                stop_with_failure("timeout while waiting for a data_valid pulse");
            end
        end
    endtask

    initial begin
        void'($urandom(69796));
        reset   = 1'b1;
        data_in = '0;
        hold_reset(mode_zero);

        // zero stream first while the output stays quiet
        collect_words(20, mode_zero);
        collect_words(30, mode_const);
        collect_words(70, mode_random);

        // reset lands between two pulses and the model restarts with the design
        repeat (2) begin
            @(negedge clk);
            drive_sample(mode_random);
        end
        hold_reset(mode_random);
        collect_words(80, mode_random);

        // let the checker see the edges after the last pulse
        repeat (4) begin
            @(negedge clk);
            drive_sample(mode_random);
        end

        if (UUT.checker_inst.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("run ended with failed checks");
        end
    end

endmodule

`default_nettype wire

// File: build.f
logic/noc_chain_pkg.sv
logic/traffic_generator.sv
logic/master_interface.sv
logic/noc_router.sv
logic/slave_interface.sv
logic/traffic_processor.sv
logic/spare_arith.sv
logic/spread_noc_chain.sv
verification/spread_noc_chain_checker.sv
verification/spread_noc_chain_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the NoC chain testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module spread_noc_chain_tb \
    -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vspread_noc_chain_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
